/* Makefile */
# Verilator build and run for the register stage testbench

VERILATOR ?= verilator
TOP       ?= regStageTb
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Fails when the log holds the fail message or has no pass message
run: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation gave no result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sources.f */
+incdir+verilog
verilog/cpuPkg.sv
verilog/writeBackIf.sv
verilog/wbStage.sv
verilog/regFile.sv
verilog/operandFetch.sv
verilog/regStage.sv
verif/tbClock.sv
verif/regStage_chk.sv
verif/regStageTb.sv

/* verif/regStageTb.sv */
// Testbench top for the register stage driving directed and LFSR stimulus into the bound checker
`timescale 1ns/1ps
`default_nettype none

module regStageTb;
    import cpuPkg::*;

    // Test length is about 2100 cycles
    localparam int CYCLE_LIMIT = 2500;
    localparam int RANDOM_CYCLES = 2000;

    logic clk;
    logic rst;

    logic [1:0]   retireEnable;
    regNum_t      retire0Num;
    regNum_t      retire1Num;
    word_t        retire0Data;
    word_t        retire1Data;
    logic [1:0]   issueValid;
    regNum_t      issue0SrcA;
    regNum_t      issue0SrcB;
    regNum_t      issue1SrcA;
    regNum_t      issue1SrcB;
    logic [1:0]   operandValid;
    operandPair_t operand0;
    operandPair_t operand1;

    logic [31:0] lfsrState = 32'd55;
    int          cycleCount = 0;

    tbClock u_tbClock (
        .clk_o (clk),
        .rst_o (rst)
    );

    regStage u_regStage (
        .clk            (clk),
        .rst            (rst),
        .retireEnable_i (retireEnable),
        .retire0Num_i   (retire0Num),
        .retire1Num_i   (retire1Num),
        .retire0Data_i  (retire0Data),
        .retire1Data_i  (retire1Data),
        .issueValid_i   (issueValid),
        .issue0SrcA_i   (issue0SrcA),
        .issue0SrcB_i   (issue0SrcB),
        .issue1SrcA_i   (issue1SrcA),
        .issue1SrcB_i   (issue1SrcB),
        .operandValid_o (operandValid),
        .operand0_o     (operand0),
        .operand1_o     (operand1)
    );

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    // Galois LFSR step for one bit
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    task automatic getBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = stepLfsr(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    // Fill value distinct for each register and built from all address bits
    function automatic word_t fillWord(input int r);
        return (32'h9E37_79B9 * (r + 1)) ^ {4{3'b000, r[4:0]}};
    endfunction

    task automatic setRetire(input logic [1:0] en, input regNum_t n0, input word_t d0,
                             input regNum_t n1, input word_t d1);
        retireEnable = en;
        retire0Num   = n0;
        retire0Data  = d0;
        retire1Num   = n1;
        retire1Data  = d1;
    endtask

    task automatic setIssue(input logic [1:0] v, input regNum_t a0, input regNum_t b0,
                            input regNum_t a1, input regNum_t b1);
        issueValid = v;
        issue0SrcA = a0;
        issue0SrcB = b0;
        issue1SrcA = a1;
        issue1SrcB = b1;
    endtask

    // Inputs change 2 ns after the edge
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    // ------------------------------
    // Watchdogs
    // ------------------------------

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    // Checker failures picked up at the falling edge
    always @(negedge clk) begin
        if (u_regStage.u_chk.errorCount != 0) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "Operand check failed");
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        logic [31:0] r;

        setRetire(2'b00, '0, '0, '0, '0);
        setIssue(2'b00, '0, '0, '0, '0);
        wait (rst === 1'b1);

        // Everything reads zero after reset
        for (int k = 0; k < 8; k++) begin
            setIssue(2'b11, regNum_t'(4 * k), regNum_t'(4 * k + 1),
                     regNum_t'(4 * k + 2), regNum_t'(4 * k + 3));
            nextCycle();
        end
        setIssue(2'b00, '0, '0, '0, '0);

        // Directed fill of every register where the r0 write is dropped
        for (int k = 0; k < 32; k += 2) begin
            setRetire(2'b11, regNum_t'(k), fillWord(k), regNum_t'(k + 1), fillWord(k + 1));
            nextCycle();
        end
        setRetire(2'b00, '0, '0, '0, '0);
        nextCycle();
        nextCycle();

        // Each register visits all four port positions
        for (int k = 0; k < 32; k++) begin
            setIssue(2'b11, regNum_t'(k), regNum_t'(k + 1),
                     regNum_t'(k + 2), regNum_t'(k + 3));
            nextCycle();
        end
        setIssue(2'b00, '0, '0, '0, '0);

        // Forwarding while the write is on the bus but not stored
        setRetire(2'b01, 5'd5, 32'hDEAD_BEEF, '0, '0);
        nextCycle();
        setRetire(2'b00, '0, '0, '0, '0);
        setIssue(2'b11, 5'd5, 5'd5, 5'd5, 5'd5);
        nextCycle();
        nextCycle();

        // Same-cycle retire is not seen, then forwarded, then stored
        setRetire(2'b10, '0, '0, 5'd9, 32'h1234_5678);
        setIssue(2'b11, 5'd9, 5'd9, 5'd9, 5'd9);
        nextCycle();
        setRetire(2'b00, '0, '0, '0, '0);
        nextCycle();
        nextCycle();

        // Slot 1 wins a write-after-write
        setRetire(2'b11, 5'd7, 32'hAAAA_0000, 5'd7, 32'hBBBB_1111);
        setIssue(2'b00, '0, '0, '0, '0);
        nextCycle();
        setRetire(2'b00, '0, '0, '0, '0);
        setIssue(2'b11, 5'd7, 5'd7, 5'd7, 5'd7);
        nextCycle();
        nextCycle();

        // Retires to r0 stay invisible
        setRetire(2'b11, 5'd0, 32'hFFFF_FFFF, 5'd0, 32'hEEEE_EEEE);
        setIssue(2'b00, '0, '0, '0, '0);
        nextCycle();
        setRetire(2'b00, '0, '0, '0, '0);
        setIssue(2'b11, 5'd0, 5'd0, 5'd0, 5'd0);
        nextCycle();
        nextCycle();

        // Random dual traffic
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            getBits(2, r);
            issueValid = r[1:0];
            getBits(5, r);
            issue0SrcA = r[4:0];
            getBits(5, r);
            issue0SrcB = r[4:0];
            getBits(5, r);
            issue1SrcA = r[4:0];
            getBits(5, r);
            issue1SrcB = r[4:0];
            getBits(2, r);
            retireEnable = r[1:0];
            getBits(5, r);
            retire0Num = r[4:0];
            getBits(5, r);
            retire1Num = r[4:0];
            getBits(32, r);
            retire0Data = r;
            getBits(32, r);
            retire1Data = r;
            nextCycle();
        end

        // Drain the last operands through the checks
        setRetire(2'b00, '0, '0, '0, '0);
        setIssue(2'b00, '0, '0, '0, '0);
        nextCycle();
        nextCycle();
        nextCycle();

        if (u_regStage.u_chk.errorCount == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "Operand check failed");
        end
    end

endmodule

`default_nettype wire

/* verif/regStage_chk.sv */
// Bound checker for the register stage with a shadow register model and concurrent operand assertions
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module regStageChk (
    input logic                    clk,
    input logic                    rst,
    input logic [`ISSUE_WIDTH-1:0] retireEnable_i,
    input cpuPkg::regNum_t         retire0Num_i,
    input cpuPkg::regNum_t         retire1Num_i,
    input cpuPkg::word_t           retire0Data_i,
    input cpuPkg::word_t           retire1Data_i,
    input logic [`ISSUE_WIDTH-1:0] issueValid_i,
    input cpuPkg::regNum_t         issue0SrcA_i,
    input cpuPkg::regNum_t         issue0SrcB_i,
    input cpuPkg::regNum_t         issue1SrcA_i,
    input cpuPkg::regNum_t         issue1SrcB_i,
    input logic [`ISSUE_WIDTH-1:0] operandValid_i,
    input cpuPkg::operandPair_t    operand0_i,
    input cpuPkg::operandPair_t    operand1_i
);
    import cpuPkg::*;

    // Count of failed assertions
    int errorCount = 0;

    // ------------------------------
    // Shadow register model
    // ------------------------------

    word_t shadow [`GPR_COUNT];
    word_t expA0;
    word_t expB0;
    word_t expA1;
    word_t expB1;

    // Slot 0 first so slot 1 wins on the same register
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int r = 0; r < `GPR_COUNT; r++) begin
                shadow[r] <= '0;
            end
        end else begin
            if (retireEnable_i[0] && (retire0Num_i != '0)) begin
                shadow[retire0Num_i] <= retire0Data_i;
            end
            if (retireEnable_i[1] && (retire1Num_i != '0)) begin
                shadow[retire1Num_i] <= retire1Data_i;
            end
        end
    end

    // What each source should see in the issue cycle
    assign expA0 = shadow[issue0SrcA_i];
    assign expB0 = shadow[issue0SrcB_i];
    assign expA1 = shadow[issue1SrcA_i];
    assign expB1 = shadow[issue1SrcB_i];

    // ------------------------------
    // Assertions
    // ------------------------------

    // Valid bits lag issue by one cycle
    aValid: assert property (@(posedge clk) disable iff (!rst)
        operandValid_i == $past(issueValid_i))
    else begin
        $error("Mismatch operandValid_o expected %h actual %h",
               $past(issueValid_i), operandValid_i);
        errorCount++;
    end

    aOp0A: assert property (@(posedge clk) disable iff (!rst)
        operandValid_i[0] |-> operand0_i.srcA == $past(expA0))
    else begin
        $error("Mismatch operand0_o.srcA expected %08h actual %08h",
               $past(expA0), operand0_i.srcA);
        errorCount++;
    end

    aOp0B: assert property (@(posedge clk) disable iff (!rst)
        operandValid_i[0] |-> operand0_i.srcB == $past(expB0))
    else begin
        $error("Mismatch operand0_o.srcB expected %08h actual %08h",
               $past(expB0), operand0_i.srcB);
        errorCount++;
    end

    aOp1A: assert property (@(posedge clk) disable iff (!rst)
        operandValid_i[1] |-> operand1_i.srcA == $past(expA1))
    else begin
        $error("Mismatch operand1_o.srcA expected %08h actual %08h",
               $past(expA1), operand1_i.srcA);
        errorCount++;
    end

    aOp1B: assert property (@(posedge clk) disable iff (!rst)
        operandValid_i[1] |-> operand1_i.srcB == $past(expB1))
    else begin
        $error("Mismatch operand1_o.srcB expected %08h actual %08h",
               $past(expB1), operand1_i.srcB);
        errorCount++;
    end

    // Idle slots keep their last pair
    aHold0: assert property (@(posedge clk) disable iff (!rst)
        !operandValid_i[0] |-> $stable(operand0_i))
    else begin
        $error("Operand pair 0 changed while slot 0 was not valid");
        errorCount++;
    end

    aHold1: assert property (@(posedge clk) disable iff (!rst)
        !operandValid_i[1] |-> $stable(operand1_i))
    else begin
        $error("Operand pair 1 changed while slot 1 was not valid");
        errorCount++;
    end

endmodule

bind regStage regStageChk u_chk (
    .clk            (clk),
    .rst            (rst),
    .retireEnable_i (retireEnable_i),
    .retire0Num_i   (retire0Num_i),
    .retire1Num_i   (retire1Num_i),
    .retire0Data_i  (retire0Data_i),
    .retire1Data_i  (retire1Data_i),
    .issueValid_i   (issueValid_i),
    .issue0SrcA_i   (issue0SrcA_i),
    .issue0SrcB_i   (issue0SrcB_i),
    .issue1SrcA_i   (issue1SrcA_i),
    .issue1SrcB_i   (issue1SrcB_i),
    .operandValid_i (operandValid_o),
    .operand0_i     (operand0_o),
    .operand1_i     (operand1_o)
);

`default_nettype wire

/* verif/tbClock.sv */
// Testbench clock and reset source that the testbench top instantiates once
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk_o,
    output logic rst_o
);

    // 40 ns period
    localparam time HALF_PERIOD = 20ns;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

    // Active low reset held for 10 cycles
    // Release comes 2 ns after an edge like the other inputs
    initial begin
        rst_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #2;
        rst_o = 1'b1;
    end

endmodule

`default_nettype wire

/* verilog/cpuPkg.sv */
// Shared register-number, word and operand types, imported by every RTL file of the register stage
`default_nettype none

`include "cpu_macros.svh"

package cpuPkg;

    // ------------------------------
    // Basic datapath types
    // ------------------------------

    // Register number, indexes r0..r31
    typedef logic [`REG_NUM_WIDTH-1:0] regNum_t;

    // One data word
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // Constant returned for r0 and on reset
    localparam word_t ZERO_WORD = '0;

    // Register number of the zero register
    localparam regNum_t ZERO_REG = '0;

    // ------------------------------
    // Issue-side operand bundle
    // ------------------------------

    // Both sources of one issued instruction
    typedef struct packed {
        word_t srcA;
        word_t srcB;
    } operandPair_t;

endpackage

`default_nettype wire

/* verilog/cpu_macros.svh */
// Register stage sizing constants, included by the package and by RTL that sizes port arrays
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ------------------------------
// Architectural register file
// ------------------------------

// Architectural registers, r0 hard-wired to zero
`define GPR_COUNT 32

// Bits needed to name one register
`define REG_NUM_WIDTH 5

// Integer datapath width
`define WORD_WIDTH 32

// ------------------------------
// Port counts
// ------------------------------

// Order is slot0 A, slot0 B, slot1 A, slot1 B
`define READ_PORTS 4

// Issue and retire slots per cycle
`define ISSUE_WIDTH 2

`endif

/* verilog/operandFetch.sv */
// Issue-side operand fetch, drives the read ports and registers both operand pairs for execute
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module operandFetch (
    input  logic                    clk,
    input  logic                    rst,
    // Issue slots
    input  logic [`ISSUE_WIDTH-1:0] issueValid_i,
    input  cpuPkg::regNum_t         issue0SrcA_i,
    input  cpuPkg::regNum_t         issue0SrcB_i,
    input  cpuPkg::regNum_t         issue1SrcA_i,
    input  cpuPkg::regNum_t         issue1SrcB_i,
    // Register file read ports
    output cpuPkg::regNum_t         readNum_o  [`READ_PORTS],
    input  cpuPkg::word_t           readData_i [`READ_PORTS],
    // Towards execute
    output logic [`ISSUE_WIDTH-1:0] operandValid_o,
    output cpuPkg::operandPair_t    operand0_o,
    output cpuPkg::operandPair_t    operand1_o
);
    import cpuPkg::*;

    // ------------------------------
    // Read port mapping
    // ------------------------------

    // Fixed order, slot-major then source
    assign readNum_o[0] = issue0SrcA_i;
    assign readNum_o[1] = issue0SrcB_i;
    assign readNum_o[2] = issue1SrcA_i;
    assign readNum_o[3] = issue1SrcB_i;

    // ------------------------------
    // Operand registers
    // ------------------------------

    // Valid bits follow issue every cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            operandValid_o <= '0;
        end else begin
            operandValid_o <= issueValid_i;
        end
    end

    // Pairs load on a valid slot, hold otherwise
    always_ff @(posedge clk) begin
        if (!rst) begin
            operand0_o <= '0;
            operand1_o <= '0;
        end else begin
            if (issueValid_i[0]) begin
                operand0_o.srcA <= readData_i[0];
                operand0_o.srcB <= readData_i[1];
            end
            if (issueValid_i[1]) begin
                operand1_o.srcA <= readData_i[2];
                operand1_o.srcB <= readData_i[3];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
// Four-read two-write register file with same-cycle forwarding, younger retire slot wins on conflict
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module regFile (
    input  logic            clk,
    input  logic            rst,
    // Read ports, combinational
    input  cpuPkg::regNum_t readNum_i  [`READ_PORTS],
    output cpuPkg::word_t   readData_o [`READ_PORTS],
    // Write-back bus
    writeBackIf.regFile     wb
);
    import cpuPkg::*;

    // ------------------------------
    // Storage and write-side views
    // ------------------------------

    // r0 has no storage
    word_t gpr [1:`GPR_COUNT-1];

    // Write slots as indexable arrays
    regNum_t writeNum  [`ISSUE_WIDTH];
    word_t   writeData [`ISSUE_WIDTH];

    // Per read port, per slot forwarding match
    logic [`ISSUE_WIDTH-1:0] hit [`READ_PORTS];

    // Both slots enabled on the same register
    logic wawConflict;

    assign writeNum[0]  = wb.writeNum0;
    assign writeNum[1]  = wb.writeNum1;
    assign writeData[0] = wb.writeData0;
    assign writeData[1] = wb.writeData1;

    assign wawConflict = (&wb.writeEnable) && (wb.writeNum0 == wb.writeNum1);

    // ------------------------------
    // Forwarding match
    // ------------------------------

    for (genvar p = 0; p < `READ_PORTS; p++) begin : gHit
        for (genvar s = 0; s < `ISSUE_WIDTH; s++) begin : gSlot
            assign hit[p][s] = wb.writeEnable[s] && (writeNum[s] == readNum_i[p]);
        end
    end

    // ------------------------------
    // Read logic
    // ------------------------------

    // Priority: r0, younger slot, older slot, storage
    always_comb begin
        for (int p = 0; p < `READ_PORTS; p++) begin
            if (readNum_i[p] == ZERO_REG) begin
                readData_o[p] = ZERO_WORD;
            end else if (hit[p][1]) begin
                readData_o[p] = writeData[1];
            end else if (hit[p][0]) begin
                readData_o[p] = writeData[0];
            end else begin
                readData_o[p] = gpr[readNum_i[p]];
            end
        end
    end

    // ------------------------------
    // Write logic
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int r = 1; r < `GPR_COUNT; r++) begin
                gpr[r] <= ZERO_WORD;
            end
        end else begin
            // Older slot, skipped when the younger one hits the same register
            if (wb.writeEnable[0] && (writeNum[0] != ZERO_REG) && !wawConflict) begin
                gpr[writeNum[0]] <= writeData[0];
            end
            // Younger slot always lands
            if (wb.writeEnable[1] && (writeNum[1] != ZERO_REG)) begin
                gpr[writeNum[1]] <= writeData[1];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/regStage.sv */
// Register stage top level, ties write-back, register file and operand fetch to plain ports
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module regStage (
    input  logic                    clk,
    input  logic                    rst,
    // Retire side
    input  logic [`ISSUE_WIDTH-1:0] retireEnable_i,
    input  cpuPkg::regNum_t         retire0Num_i,
    input  cpuPkg::regNum_t         retire1Num_i,
    input  cpuPkg::word_t           retire0Data_i,
    input  cpuPkg::word_t           retire1Data_i,
    // Issue side
    input  logic [`ISSUE_WIDTH-1:0] issueValid_i,
    input  cpuPkg::regNum_t         issue0SrcA_i,
    input  cpuPkg::regNum_t         issue0SrcB_i,
    input  cpuPkg::regNum_t         issue1SrcA_i,
    input  cpuPkg::regNum_t         issue1SrcB_i,
    // Operands for execute
    output logic [`ISSUE_WIDTH-1:0] operandValid_o,
    output cpuPkg::operandPair_t    operand0_o,
    output cpuPkg::operandPair_t    operand1_o
);
    import cpuPkg::*;

    // ------------------------------
    // Internal connections
    // ------------------------------

    writeBackIf wbBus ();

    regNum_t readNum  [`READ_PORTS];
    word_t   readData [`READ_PORTS];

    // Retire results, one cycle to the bus
    wbStage u_wbStage (
        .clk            (clk),
        .rst            (rst),
        .retireEnable_i (retireEnable_i),
        .retire0Num_i   (retire0Num_i),
        .retire1Num_i   (retire1Num_i),
        .retire0Data_i  (retire0Data_i),
        .retire1Data_i  (retire1Data_i),
        .wb             (wbBus)
    );

    // Storage plus forwarding
    regFile u_regFile (
        .clk        (clk),
        .rst        (rst),
        .readNum_i  (readNum),
        .readData_o (readData),
        .wb         (wbBus)
    );

    // Issue reads, operands one cycle later
    operandFetch u_operandFetch (
        .clk            (clk),
        .rst            (rst),
        .issueValid_i   (issueValid_i),
        .issue0SrcA_i   (issue0SrcA_i),
        .issue0SrcB_i   (issue0SrcB_i),
        .issue1SrcA_i   (issue1SrcA_i),
        .issue1SrcB_i   (issue1SrcB_i),
        .readNum_o      (readNum),
        .readData_i     (readData),
        .operandValid_o (operandValid_o),
        .operand0_o     (operand0_o),
        .operand1_o     (operand1_o)
    );

endmodule

`default_nettype wire

/* verilog/wbStage.sv */
// Write-back pipeline register that captures both retiring results and drives the write-back bus
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module wbStage (
    input  logic                    clk,
    input  logic                    rst,
    // Retire slots from the execute side
    input  logic [`ISSUE_WIDTH-1:0] retireEnable_i,
    input  cpuPkg::regNum_t         retire0Num_i,
    input  cpuPkg::regNum_t         retire1Num_i,
    input  cpuPkg::word_t           retire0Data_i,
    input  cpuPkg::word_t           retire1Data_i,
    // Towards the register file
    writeBackIf.wbStage             wb
);
    import cpuPkg::*;

    // ------------------------------
    // Pipeline registers
    // ------------------------------

    logic [`ISSUE_WIDTH-1:0] enableQ;
    regNum_t                 num0Q;
    regNum_t                 num1Q;
    word_t                   data0Q;
    word_t                   data1Q;

    // Slot enables cleared while in reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            enableQ <= '0;
        end else begin
            enableQ <= retireEnable_i;
        end
    end

    // Numbers and data captured every cycle
    // Writes to r0 pass through and the register file drops them
    always_ff @(posedge clk) begin
        num0Q  <= retire0Num_i;
        num1Q  <= retire1Num_i;
        data0Q <= retire0Data_i;
        data1Q <= retire1Data_i;
    end

    // ------------------------------
    // Drive the bus
    // ------------------------------

    assign wb.writeEnable = enableQ;
    assign wb.writeNum0   = num0Q;
    assign wb.writeNum1   = num1Q;
    assign wb.writeData0  = data0Q;
    assign wb.writeData1  = data1Q;

endmodule

`default_nettype wire

/* verilog/writeBackIf.sv */
// Write-back bus from the write-back stage into the register file, both retire slots at once
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

interface writeBackIf;
    import cpuPkg::*;

    // One enable bit per retire slot
    logic [`ISSUE_WIDTH-1:0] writeEnable;

    // Slot 0 is the older instruction
    regNum_t writeNum0;
    word_t   writeData0;

    // Slot 1 is the younger one, wins on a tie
    regNum_t writeNum1;
    word_t   writeData1;

    // Producer side
    modport wbStage (
        output writeEnable, writeNum0, writeNum1, writeData0, writeData1
    );

    // Consumer side, also used for forwarding
    modport regFile (
        input writeEnable, writeNum0, writeNum1, writeData0, writeData1
    );

endinterface

`default_nettype wire
